//--- bench/hazardTests.svh
//////////////////////////////////////////////////
// Instruction encoders
//////////////////////////////////////////////////
function automatic hazardPkg::instrT encodeWord(input hazardPkg::opcodeT op,
    input hazardPkg::regIdT a, input hazardPkg::regIdT b, input hazardPkg::regIdT c);
  hazardPkg::instrT w;
  w.opcode = op;
  w.fieldA = a;   // Rd, or store data
  w.fieldB = b;   // Rs or base
  w.fieldC = c;
  return w;
endfunction

// pcs r0 writes nothing useful and sets no flags
function automatic hazardPkg::instrT nopWord();
  return encodeWord(hazardPkg::pcs, 4'h0, 4'h0, 4'h0);
endfunction

// Random register 1 to 15
function automatic hazardPkg::regIdT randomReg();
  return hazardPkg::regIdT'(1 + ($unsigned($random(seed)) % 15));
endfunction

// Always differs from r and is never r0
function automatic hazardPkg::regIdT otherReg(input hazardPkg::regIdT r);
  return hazardPkg::regIdT'((r % 15) + 1);
endfunction

//////////////////////////////////////////////////
// Stimulus helpers
//////////////////////////////////////////////////
task automatic applyReset();
  reset = 1'b1;
  repeat (5) @(posedge clk);
  #1;
  reset = 1'b0;
endtask

// Holds the word while fetch is stalled
task automatic feedWord(input hazardPkg::instrT w);
  logic stalled;
  instr   = w;
  stalled = 1'b1;
  while (stalled) begin
    @(negedge clk);              // Outputs settled
    stalled = pcStall;
    if (pcStall) stallCycles++;
    if (ifIdStall) holdCycles++;
    if (idFlush) flushCycles++;
    checkBit("ifFlush", ifFlush, 1'b0);
    @(posedge clk);
    #1;
  end
endtask

// Pushes older words out of EX and MEM
task automatic drain();
  repeat (3) feedWord(nopWord());
  stallCycles = 0;
  holdCycles  = 0;
  flushCycles = 0;
endtask

task automatic runPair(input string what, input hazardPkg::instrT first,
    input hazardPkg::instrT second, input int expStalls);
  drain();
  feedWord(first);
  feedWord(second);
  feedWord(nopWord());
  feedWord(nopWord());
  checkCount({what, " stall cycles"}, stallCycles, expStalls);
  checkCount({what, " IF/ID stall cycles"}, holdCycles, expStalls);
  checkCount({what, " flush cycles"}, flushCycles, expStalls);   // Every hazard flushes
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////
task automatic testReset();
  int errorsBefore;
  errorsBefore = errorCount;
  applyReset();
  repeat (6) begin
    @(negedge clk);
    checkBit("pcStall after reset", pcStall, 1'b0);
    checkBit("ifIdStall after reset", ifIdStall, 1'b0);
    checkBit("idFlush after reset", idFlush, 1'b0);
    checkBit("ifFlush after reset", ifFlush, 1'b0);
    @(posedge clk);
    #1;
  end
  reportTest("reset", errorsBefore);
endtask

task automatic testLoadUse();
  hazardPkg::regIdT rX;
  hazardPkg::regIdT rY;
  int errorsBefore;
  errorsBefore = errorCount;
  rX = randomReg();
  rY = otherReg(rX);
  runPair("lw then add Rs", encodeWord(hazardPkg::lw, rX, 4'h0, 4'h2),
          encodeWord(hazardPkg::add, rY, rX, rY), 1);
  runPair("lw then add Rt", encodeWord(hazardPkg::lw, rX, 4'h0, 4'h2),
          encodeWord(hazardPkg::add, rY, rY, rX), 1);
  runPair("lw then sw data", encodeWord(hazardPkg::lw, rX, 4'h0, 4'h2),
          encodeWord(hazardPkg::sw, rX, rY, 4'h1), 0);       // Only the data reg matches
  runPair("lw r0 then reader", encodeWord(hazardPkg::lw, 4'h0, rY, 4'h2),
          encodeWord(hazardPkg::add, rY, 4'h0, 4'h0), 0);
  reportTest("load-to-use", errorsBefore);
endtask

task automatic testBAfterFlags();
  hazardPkg::regIdT rX;
  int errorsBefore;
  errorsBefore = errorCount;
  rX = randomReg();
  runPair("add then b", encodeWord(hazardPkg::add, rX, rX, rX),
          encodeWord(hazardPkg::b, 4'h0, 4'h0, 4'h3), 1);
  runPair("sub then b", encodeWord(hazardPkg::sub, rX, rX, rX),
          encodeWord(hazardPkg::b, 4'h0, 4'h0, 4'h3), 1);
  runPair("xor then b", encodeWord(hazardPkg::xorOp, rX, rX, rX),
          encodeWord(hazardPkg::b, 4'h0, 4'h0, 4'h3), 1);
  runPair("lw then b", encodeWord(hazardPkg::lw, rX, 4'h0, 4'h0),
          encodeWord(hazardPkg::b, 4'h0, 4'h0, 4'h3), 0);     // Loads set no flags
  runPair("pcs then b", encodeWord(hazardPkg::pcs, rX, 4'h0, 4'h0),
          encodeWord(hazardPkg::b, 4'h0, 4'h0, 4'h3), 0);
  reportTest("b after flags", errorsBefore);
endtask

task automatic testBrRegister();
  hazardPkg::regIdT rX;
  int errorsBefore;
  errorsBefore = errorCount;
  rX = randomReg();
  // EX hazard, then MEM hazard behind the bubble
  runPair("llb then br same", encodeWord(hazardPkg::llb, rX, 4'h5, 4'h5),
          encodeWord(hazardPkg::br, 4'h0, rX, 4'h0), 2);
  runPair("llb then br other", encodeWord(hazardPkg::llb, rX, 4'h5, 4'h5),
          encodeWord(hazardPkg::br, 4'h0, otherReg(rX), 4'h0), 0);
  reportTest("br register", errorsBefore);
endtask

task automatic testRedirect();
  hazardPkg::regIdT rX;
  int errorsBefore;
  errorsBefore = errorCount;
  rX = randomReg();
  drain();
  feedWord(encodeWord(hazardPkg::lw, rX, 4'h0, 4'h0));  // lw now in ID
  instr    = encodeWord(hazardPkg::add, rX, rX, rX);     // Reader on the wrong path
  updatePc = 1'b1;
  @(negedge clk);
  checkBit("ifFlush with updatePc", ifFlush, 1'b1);
  checkBit("pcStall with updatePc", pcStall, 1'b0);
  @(posedge clk);
  #1;
  updatePc = 1'b0;
  instr    = nopWord();
  @(negedge clk);                                        // Bubble in ID
  checkBit("ifFlush after pulse", ifFlush, 1'b0);
  checkBit("pcStall after flush", pcStall, 1'b0);
  checkBit("idFlush after flush", idFlush, 1'b0);
  @(posedge clk);
  #1;
  reportTest("redirect", errorsBefore);
endtask

task automatic testHalt();
  int errorsBefore;
  errorsBefore = errorCount;
  drain();
  feedWord(encodeWord(hazardPkg::hlt, 4'h0, 4'h0, 4'h0));
  instr = nopWord();
  repeat (4) begin                                       // Frozen until reset
    @(negedge clk);
    checkBit("pcStall on halt", pcStall, 1'b1);
    checkBit("ifIdStall on halt", ifIdStall, 1'b1);
    checkBit("idFlush on halt", idFlush, 1'b0);
    @(posedge clk);
    #1;
  end
  applyReset();
  @(negedge clk);
  checkBit("pcStall after halt reset", pcStall, 1'b0);
  checkBit("ifIdStall after halt reset", ifIdStall, 1'b0);
  @(posedge clk);
  #1;
  reportTest("halt", errorsBefore);
endtask

//--- bench/hazardTb.sv
`timescale 1ns/10ps

// Testbench top for the pipeline control model
module hazardTb;

  localparam int cycleLimit = 300;  // About twice the summed test lengths

  logic             clk = 1'b0;
  logic             reset;
  hazardPkg::instrT instr;
  logic             updatePc;
  logic             pcStall;
  logic             ifIdStall;
  logic             idFlush;
  logic             ifFlush;

  integer seed = 52372;      // Register picks
  int     cycleCount = 0;
  int     errorCount = 0;    // Failed checks so far
  int     passCount = 0;     // Finished tests without errors
  int     failCount = 0;
  int     stallCycles;       // Counted by the feeder
  int     holdCycles;        // IF/ID stall cycles
  int     flushCycles;

  always #4 clk = ~clk;      // 8 ns period

  hazardTop i_hazardTop (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .updatePc  (updatePc),
    .pcStall   (pcStall),
    .ifIdStall (ifIdStall),
    .idFlush   (idFlush),
    .ifFlush   (ifFlush)
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic checkBit(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic checkCount(input string what, input int actual, input int expected);
    if (actual != expected) begin
      errorCount++;
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // One line per finished test
  task automatic reportTest(input string name, input int errorsBefore);
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("test %s done, ok", name);
    end else begin
      failCount++;
      $display("test %s done, %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  `include "hazardTests.svh"

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    reset    = 1'b1;
    updatePc = 1'b0;
    instr    = encodeWord(hazardPkg::add, 4'h0, 4'h0, 4'h0);  // add r0 stream
    testReset();
    testLoadUse();
    testBAfterFlags();
    testBrRegister();
    testRedirect();
    testHalt();          // Ends in a reset
    $display("tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- source/fetchDecode.sv
`timescale 1ns/10ps
`default_nettype none

// IF/ID instruction latch and decoder
module fetchDecode (
  input  logic              clk,
  input  logic              reset,
  input  hazardPkg::instrT  instr,      // Fetched word from IF
  input  logic              ifIdStall,  // Hold the latch
  input  logic              ifFlush,    // Kill the latched word

  output hazardPkg::regIdT  srcReg1,    // First read register
  output hazardPkg::regIdT  srcReg2,    // Second read register
  output hazardPkg::regIdT  destReg,    // Write register
  output logic              regWrite,
  output logic              memEnable,
  output logic              memWrite,
  output logic              zEn,        // Sets Z flag
  output logic              nvEn,       // Sets N and V flags
  output logic              branch,     // B or BR
  output logic              br,         // BR only
  output logic              hlt
);

  hazardPkg::instrT ifIdInstr;  // Latched word
  logic             ifIdValid;  // Low means bubble

  ////////////////////////////////////////////////////
  // IF/ID latch
  ////////////////////////////////////////////////////
  // Flush wins over stall
  always_ff @(posedge clk) begin
    if (reset || ifFlush) begin
      ifIdValid <= 1'b0;
    end else if (!ifIdStall) begin
      ifIdValid <= 1'b1;
    end
  end

  // Word only matters while valid
  always_ff @(posedge clk) begin
    if (!ifIdStall) begin
      ifIdInstr <= instr;
    end
  end

  ////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////
  always_comb begin
    srcReg1   = hazardPkg::zeroReg;  // Unused fields read r0
    srcReg2   = hazardPkg::zeroReg;
    destReg   = hazardPkg::zeroReg;
    regWrite  = 1'b0;
    memEnable = 1'b0;
    memWrite  = 1'b0;
    zEn       = 1'b0;
    nvEn      = 1'b0;
    branch    = 1'b0;
    br        = 1'b0;
    hlt       = 1'b0;
    if (ifIdValid) begin  // Bubble decodes to all zeros
      case (ifIdInstr.opcode)
        hazardPkg::add, hazardPkg::sub: begin
          regWrite = 1'b1;
          nvEn     = 1'b1;
          zEn      = 1'b1;
          destReg  = ifIdInstr.fieldA;
          srcReg1  = ifIdInstr.fieldB;
          srcReg2  = ifIdInstr.fieldC;
        end
        hazardPkg::xorOp, hazardPkg::sll, hazardPkg::sra, hazardPkg::ror: begin
          regWrite = 1'b1;
          zEn      = 1'b1;   // Z only
          destReg  = ifIdInstr.fieldA;
          srcReg1  = ifIdInstr.fieldB;
          srcReg2  = ifIdInstr.fieldC;
        end
        hazardPkg::red, hazardPkg::paddsb: begin
          regWrite = 1'b1;   // No flags
          destReg  = ifIdInstr.fieldA;
          srcReg1  = ifIdInstr.fieldB;
          srcReg2  = ifIdInstr.fieldC;
        end
        hazardPkg::lw: begin
          regWrite  = 1'b1;
          memEnable = 1'b1;
          destReg   = ifIdInstr.fieldA;
          srcReg1   = ifIdInstr.fieldB;  // Base
        end
        hazardPkg::sw: begin
          memEnable = 1'b1;
          memWrite  = 1'b1;
          srcReg1   = ifIdInstr.fieldB;  // Base
          srcReg2   = ifIdInstr.fieldA;  // Store data
        end
        hazardPkg::llb, hazardPkg::lhb: begin
          regWrite = 1'b1;
          destReg  = ifIdInstr.fieldA;
          srcReg1  = ifIdInstr.fieldA;   // Keeps the other byte
        end
        hazardPkg::b: branch = 1'b1;
        hazardPkg::br: begin
          branch  = 1'b1;
          br      = 1'b1;
          srcReg1 = ifIdInstr.fieldB;    // Target register
        end
        hazardPkg::pcs: begin
          regWrite = 1'b1;
          destReg  = ifIdInstr.fieldA;
        end
        default: hlt = 1'b1;             // Only hlt is left
      endcase
    end
  end

  // Halt stays in ID until reset or a redirect
  haltHoldsFetch: assert property (@(posedge clk) disable iff (reset)
    (hlt && !ifFlush) |=> hlt)
    else $error("halt left ID without reset or flush");

endmodule

`default_nettype wire

//--- source/hazardDetectionUnit.sv
`timescale 1ns/10ps
`default_nettype none

// Stall and flush logic for load-to-use, B, BR and halt
module hazardDetectionUnit (
  input  hazardPkg::regIdT  srcReg1,        // Rs in ID
  input  hazardPkg::regIdT  srcReg2,        // Rt in ID
  input  logic              idExRegWrite,
  input  hazardPkg::regIdT  idExDest,       // Rd in EX
  input  hazardPkg::regIdT  exMemDest,      // Rd in MEM
  input  logic              exMemRegWrite,
  input  logic              idExMemEnable,
  input  logic              idExMemWrite,
  input  logic              memWrite,       // ID instruction is a store
  input  logic              idExZEn,        // EX sets Z
  input  logic              idExNvEn,       // EX sets N and V
  input  logic              branch,         // B or BR in ID
  input  logic              br,             // BR in ID
  input  logic              updatePc,       // Redirect from branch resolution
  input  logic              hlt,            // Halt in ID

  output logic              pcStall,
  output logic              ifIdStall,
  output logic              idFlush,        // Bubble into ID/EX
  output logic              ifFlush         // Kill IF/ID
);

  logic idExMemRead;    // EX holds a load
  logic idExFlagSet;    // EX will change condition codes
  logic loadUseHazard;
  logic bHazard;
  logic exToIdBr;       // EX writes the BR target reg
  logic memToIdBr;      // MEM writes the BR target reg
  logic brInstr;
  logic brHazard;
  logic anyHazard;

  ////////////////////////////////////////////////////
  // Load-to-use
  ////////////////////////////////////////////////////
  assign idExMemRead = idExMemEnable && !idExMemWrite;  // lw, not sw

  // Store data on srcReg2 comes late enough through MEM forwarding
  always_comb begin
    loadUseHazard = 1'b0;
    if (idExMemRead && (idExDest != hazardPkg::zeroReg)) begin
      if (idExDest == srcReg1) begin
        loadUseHazard = 1'b1;
      end else if ((idExDest == srcReg2) && !memWrite) begin
        loadUseHazard = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Branch hazards
  ////////////////////////////////////////////////////
  assign idExFlagSet = idExZEn || idExNvEn;

  // B waits until flags are written
  assign bHazard = branch && idExFlagSet;

  // BR reads its target in ID so no forwarding helps
  assign exToIdBr  = idExRegWrite && (idExDest != hazardPkg::zeroReg)
                     && (idExDest == srcReg1);
  assign memToIdBr = exMemRegWrite && (exMemDest != hazardPkg::zeroReg)
                     && (exMemDest == srcReg1);

  assign brInstr  = branch && br;  // Decoder raises both for BR
  assign brHazard = brInstr && (idExFlagSet || exToIdBr || memToIdBr);

  assign anyHazard = loadUseHazard || bHazard || brHazard;

  ////////////////////////////////////////////////////
  // Stall and flush outputs
  ////////////////////////////////////////////////////
  assign ifIdStall = hlt || anyHazard;  // Halt freezes fetch
  assign pcStall   = ifIdStall;         // PC moves with IF/ID
  assign idFlush   = anyHazard;         // Halt itself is not flushed
  assign ifFlush   = updatePc;          // Wrong-path word

endmodule

`default_nettype wire

//--- source/hazardPkg.sv
////////////////////////////////////////////////////
// Shared ISA types for the pipeline control model
////////////////////////////////////////////////////
package hazardPkg;

  // Register number
  // Sixteen registers with r0 wired to zero
  typedef logic [3:0] regIdT;

  // Hard-wired zero register
  localparam regIdT zeroReg = 4'h0;

  // Opcode field of an instruction word
  typedef enum logic [3:0] {
    add    = 4'h0,  // Rd = Rs + Rt, sets N V Z
    sub    = 4'h1,  // Rd = Rs - Rt, sets N V Z
    xorOp  = 4'h2,  // Sets Z only
    red    = 4'h3,  // Reduction add, no flags
    sll    = 4'h4,  // Shift left logical, sets Z
    sra    = 4'h5,  // Shift right arithmetic, sets Z
    ror    = 4'h6,  // Rotate right, sets Z
    paddsb = 4'h7,  // Parallel sub-word add, no flags
    lw     = 4'h8,  // Load word
    sw     = 4'h9,  // Store word
    llb    = 4'hA,  // Load low byte into Rd
    lhb    = 4'hB,  // Load high byte into Rd
    b      = 4'hC,  // Conditional branch on flags
    br     = 4'hD,  // Conditional branch to register
    pcs    = 4'hE,  // Save PC into Rd
    hlt    = 4'hF   // Halt
  } opcodeT;

  ////////////////////////////////////////////////////
  // Instruction word layout
  ////////////////////////////////////////////////////
  // Bits 15..12 opcode
  // Bits 11..8  field A (Rd for most, data reg for sw)
  // Bits 7..4   field B (Rs or base)
  // Bits 3..0   field C (Rt or offset)
  typedef struct packed {
    opcodeT opcode;  // Bits 15..12
    regIdT  fieldA;  // Bits 11..8
    regIdT  fieldB;  // Bits 7..4
    regIdT  fieldC;  // Bits 3..0
  } instrT;

endpackage

//--- source/hazardTop.sv
`timescale 1ns/10ps
`default_nettype none

// Pipeline control top level
module hazardTop (
  input  logic              clk,
  input  logic              reset,
  input  hazardPkg::instrT  instr,      // One word per cycle from fetch
  input  logic              updatePc,   // Redirect pulse

  output logic              pcStall,
  output logic              ifIdStall,
  output logic              idFlush,
  output logic              ifFlush
);

  ////////////////////////////////////////////////////
  // Decoded ID fields
  ////////////////////////////////////////////////////
  hazardPkg::regIdT srcReg1;
  hazardPkg::regIdT srcReg2;
  hazardPkg::regIdT destReg;
  logic             regWrite;
  logic             memEnable;
  logic             memWrite;
  logic             zEn;
  logic             nvEn;
  logic             branch;
  logic             br;
  logic             hlt;

  // Older stages
  logic             idExRegWrite;
  hazardPkg::regIdT idExDest;
  logic             idExMemEnable;
  logic             idExMemWrite;
  logic             idExZEn;
  logic             idExNvEn;
  logic             exMemRegWrite;
  hazardPkg::regIdT exMemDest;

  fetchDecode i_fetchDecode (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .ifIdStall (ifIdStall),
    .ifFlush   (ifFlush),
    .srcReg1   (srcReg1),
    .srcReg2   (srcReg2),
    .destReg   (destReg),
    .regWrite  (regWrite),
    .memEnable (memEnable),
    .memWrite  (memWrite),
    .zEn       (zEn),
    .nvEn      (nvEn),
    .branch    (branch),
    .br        (br),
    .hlt       (hlt)
  );

  stageTracker i_stageTracker (
    .clk           (clk),
    .reset         (reset),
    .idFlush       (idFlush),
    .regWrite      (regWrite),
    .destReg       (destReg),
    .memEnable     (memEnable),
    .memWrite      (memWrite),
    .zEn           (zEn),
    .nvEn          (nvEn),
    .idExRegWrite  (idExRegWrite),
    .idExDest      (idExDest),
    .idExMemEnable (idExMemEnable),
    .idExMemWrite  (idExMemWrite),
    .idExZEn       (idExZEn),
    .idExNvEn      (idExNvEn),
    .exMemRegWrite (exMemRegWrite),
    .exMemDest     (exMemDest)
  );

  hazardDetectionUnit i_hazardDetectionUnit (
    .srcReg1       (srcReg1),
    .srcReg2       (srcReg2),
    .idExRegWrite  (idExRegWrite),
    .idExDest      (idExDest),
    .exMemDest     (exMemDest),
    .exMemRegWrite (exMemRegWrite),
    .idExMemEnable (idExMemEnable),
    .idExMemWrite  (idExMemWrite),
    .memWrite      (memWrite),
    .idExZEn       (idExZEn),
    .idExNvEn      (idExNvEn),
    .branch        (branch),
    .br            (br),
    .updatePc      (updatePc),
    .hlt           (hlt),
    .pcStall       (pcStall),
    .ifIdStall     (ifIdStall),
    .idFlush       (idFlush),
    .ifFlush       (ifFlush)
  );

endmodule

`default_nettype wire

//--- source/stageTracker.sv
`timescale 1ns/10ps
`default_nettype none

// ID/EX and EX/MEM control records
module stageTracker (
  input  logic              clk,
  input  logic              reset,
  input  logic              idFlush,        // Insert bubble into ID/EX
  input  logic              regWrite,       // Decoded control from ID
  input  hazardPkg::regIdT  destReg,
  input  logic              memEnable,
  input  logic              memWrite,
  input  logic              zEn,
  input  logic              nvEn,

  output logic              idExRegWrite,
  output hazardPkg::regIdT  idExDest,
  output logic              idExMemEnable,
  output logic              idExMemWrite,
  output logic              idExZEn,
  output logic              idExNvEn,
  output logic              exMemRegWrite,
  output hazardPkg::regIdT  exMemDest
);

  ////////////////////////////////////////////////////
  // ID/EX record
  ////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || idFlush) begin  // Bubble
      idExRegWrite  <= 1'b0;
      idExDest      <= '0;
      idExMemEnable <= 1'b0;
      idExMemWrite  <= 1'b0;
      idExZEn       <= 1'b0;
      idExNvEn      <= 1'b0;
    end else begin
      idExRegWrite  <= regWrite;
      idExDest      <= destReg;
      idExMemEnable <= memEnable;
      idExMemWrite  <= memWrite;
      idExZEn       <= zEn;
      idExNvEn      <= nvEn;
    end
  end

  ////////////////////////////////////////////////////
  // EX/MEM record
  ////////////////////////////////////////////////////
  // Only the write-back target is needed past EX
  always_ff @(posedge clk) begin
    if (reset) begin
      exMemRegWrite <= 1'b0;
      exMemDest     <= '0;
    end else begin
      exMemRegWrite <= idExRegWrite;
      exMemDest     <= idExDest;
    end
  end

  // Flushed slot must not write or set flags
  flushGivesBubble: assert property (@(posedge clk) disable iff (reset)
    idFlush |=> !(idExRegWrite || idExZEn || idExNvEn))
    else $error("ID/EX not a bubble after idFlush");

endmodule

`default_nettype wire

//--- src.f
+incdir+bench
source/hazardPkg.sv
source/fetchDecode.sv
source/stageTracker.sv
source/hazardDetectionUnit.sv
source/hazardTop.sv
bench/hazardTb.sv
